//--- build.f
verilog/pgm_arb_pkg.sv
verilog/read_cmd_if.sv
verilog/read_tag_if.sv
verilog/request_scheduler.sv
verilog/ddram_issue.sv
verilog/read_return_router.sv
verilog/loader_write_latch.sv
verilog/pgm_ddram_arbiter.sv
test/tb_ddram_model.sv
test/tb_pgm_ddram_arbiter.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    --top-module tb_pgm_ddram_arbiter \
    -f build.f -o sim_tb

# The simulator exits non-zero on failure, so keep its status out of set -e
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"

//--- test/tb_pgm_ddram_arbiter.sv
`timescale 1ns/1ps

module tb_pgm_ddram_arbiter;
    import pgm_arb_pkg::*;

    localparam int ISSUE_DEPTH     = 2;
    localparam int MAX_OUTSTANDING = 4;
    localparam int K_LOAD0 = 0, K_LOAD1 = 1, K_CPU = 2, K_VIDEO = 3, K_AUDIO = 4;
    localparam int K_ALL = 5, K_HOLD = 6, K_RANDOM = 7;
    localparam int NUM_ROWS = 10;

    typedef struct {
        string       name;
        int          kind;
        logic [28:0] addr;
        logic [15:0] wdata;
    } row_t;

    logic fixed_50m_clk = 1'b0;
    logic reset;
    logic cpu_req, video_req, audio_req;
    cpu_addr_t cpu_addr;
    ddram_addr_t video_addr, audio_addr;
    logic ioctl_download, ioctl_wr, ioctl_wait;
    logic [26:0] ioctl_addr;
    logic [15:0] ioctl_dout;
    logic [7:0] ioctl_index;
    logic ddram_rd, ddram_we, ddram_busy, ddram_dout_ready;
    ddram_addr_t ddram_addr, wr_addr;
    ddram_data_t ddram_din, ddram_dout, wr_data;
    ddram_be_t ddram_be, wr_be;
    int wr_count, max_in_flight;
    logic cpu_ack, video_ack, audio_ack;
    cpu_word_t cpu_data;
    ddram_data_t video_data, audio_data;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr = 32'hb46927e9;
    ddram_addr_t rd_log[$];  // Read addresses accepted by DDRAM
    string       cur_name;
    int          error_count = 0;
    logic        cpu_wait_ack = 0, video_wait_ack = 0, audio_wait_ack = 0;
    cpu_word_t   cpu_exp;
    ddram_data_t video_exp, audio_exp;

    pgm_ddram_arbiter #(
        .ISSUE_DEPTH(ISSUE_DEPTH), .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) pgm_ddram_arbiter_inst (.*);

    tb_ddram_model ddram_model_inst (.*);

    always #10 fixed_50m_clk = ~fixed_50m_clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic ddram_data_t expected_beat(input ddram_addr_t a);
        return {a, 3'b101, ~a, 3'b010};
    endfunction

    // Word picked by address bits 2:1, bytes swapped
    function automatic cpu_word_t expected_cpu_word(input cpu_addr_t a);
        ddram_data_t b;
        cpu_word_t   w;
        b = expected_beat(ddram_addr_t'(a >> 2));
        w = b[a[1:0] * 16 +: 16];
        return {w[7:0], w[15:8]};
    endfunction

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cpu_word_t exp, input cpu_word_t act);
        if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_beat(input string name, input ddram_data_t exp, input ddram_data_t act);
        if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input ddram_addr_t exp, input ddram_addr_t act);
        if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_be(input string name, input ddram_be_t exp, input ddram_be_t act);
        if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_client(input string name, input client_e exp, input client_e act);
        if (exp !== act) fail_now($sformatf("mismatch %s expected %s actual %s",
                                            name, exp.name(), act.name()));
    endtask

    // Acks are sampled at the edge, inputs change 1 ns later
    task automatic step_cycle();
        @(posedge fixed_50m_clk);
        if (cpu_ack) begin
            if (!cpu_wait_ack) fail_now({cur_name, ": cpu ack without a request"});
            check_word(cur_name, cpu_exp, cpu_data);
            cpu_wait_ack = 0;
        end
        if (video_ack) begin
            if (!video_wait_ack) fail_now({cur_name, ": video ack without a request"});
            check_beat(cur_name, video_exp, video_data);
            video_wait_ack = 0;
        end
        if (audio_ack) begin
            if (!audio_wait_ack) fail_now({cur_name, ": audio ack without a request"});
            check_beat(cur_name, audio_exp, audio_data);
            audio_wait_ack = 0;
        end
        #1;
        cpu_req   = 0;
        video_req = 0;
        audio_req = 0;
        ioctl_wr  = 0;
    endtask

    task automatic issue_cpu(input cpu_addr_t a);
        cpu_req = 1;
        cpu_addr = a;
        cpu_exp = expected_cpu_word(a);
        cpu_wait_ack = 1;
    endtask

    task automatic issue_video(input ddram_addr_t a);
        video_req = 1;
        video_addr = a;
        video_exp = expected_beat(a);
        video_wait_ack = 1;
    endtask

    task automatic issue_audio(input ddram_addr_t a);
        audio_req = 1;
        audio_addr = a;
        audio_exp = expected_beat(a);
        audio_wait_ack = 1;
    endtask

    task automatic wait_acks();
        while (cpu_wait_ack || video_wait_ack || audio_wait_ack) step_cycle();
    endtask

    task automatic run_loader(input row_t r, input logic [7:0] index);
        int old_count;
        old_count = wr_count;
        ioctl_download = 1;
        step_cycle();
        ioctl_wr = 1;
        ioctl_index = index;
        ioctl_addr = r.addr[26:0];
        ioctl_dout = r.wdata;
        step_cycle();
        if (index == LOADER_ROM_INDEX) begin
            while (wr_count == old_count) begin
                if (!ioctl_wait) begin
                    fail_now({r.name, ": ioctl_wait low before the write was accepted"});
                end
                step_cycle();
            end
            check_addr(r.name, ddram_addr_t'(r.addr[26:0] >> 3), wr_addr);
            check_beat(r.name, {4{r.wdata}}, wr_data);
            check_be(r.name, 8'h03 << (2 * r.addr[2:1]), wr_be);
        end else begin
            repeat (10) step_cycle();
            if (wr_count != old_count || ioctl_wait)
                fail_now({r.name, ": sound RAM write reached the DDRAM port"});
        end
        ioctl_download = 0;
        step_cycle();
    endtask

    // Issued read order tells which client was granted first
    function automatic client_e client_of(input ddram_addr_t a, input ddram_addr_t base);
        if (a == base) return CLIENT_CPU;
        if (a == base + 1) return CLIENT_VIDEO;
        return CLIENT_AUDIO;
    endfunction

    task automatic run_three(input row_t r, input bit hold);
        rd_log.delete();
        if (hold) ioctl_download = 1;
        issue_cpu({r.addr[20:0], 2'b10});
        issue_video(r.addr + 1);
        issue_audio(r.addr + 2);
        if (hold) begin
            repeat (20) step_cycle();
            ioctl_download = 0;
        end
        wait_acks();
        if (rd_log.size() != 3) fail_now({r.name, ": wrong number of reads at the DDRAM port"});
        check_client(r.name, CLIENT_CPU, client_of(rd_log[0], r.addr));
        check_client(r.name, CLIENT_VIDEO, client_of(rd_log[1], r.addr));
        check_client(r.name, CLIENT_AUDIO, client_of(rd_log[2], r.addr));
    endtask

    task automatic run_random(input row_t r, input int total);
        int n_cpu, n_video, n_audio;
        n_cpu = 0;
        n_video = 0;
        n_audio = 0;
        while (n_cpu < total || n_video < total || n_audio < total) begin
            step_cycle();
            if (!cpu_wait_ack && n_cpu < total && take_bits(1)) begin
                issue_cpu(cpu_addr_t'(take_bits(23)));
                n_cpu++;
            end
            if (!video_wait_ack && n_video < total && take_bits(1)) begin
                issue_video(ddram_addr_t'(take_bits(29)));
                n_video++;
            end
            if (!audio_wait_ack && n_audio < total && take_bits(1)) begin
                issue_audio(ddram_addr_t'(take_bits(29)));
                n_audio++;
            end
        end
        wait_acks();
        if (max_in_flight > MAX_OUTSTANDING) fail_now({r.name, ": too many reads in flight"});
    endtask

    always @(posedge fixed_50m_clk) begin
        if (!reset && ddram_rd && !ddram_busy) begin
            if (ioctl_download) fail_now("read accepted while a download was running");
            rd_log.push_back(ddram_addr);
        end
    end

    initial begin
        repeat (NUM_ROWS * 200) @(posedge fixed_50m_clk);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        rows[0] = '{"loader_rom_lane0", K_LOAD0, 29'h0001230, 16'ha55a};
        rows[1] = '{"loader_rom_lane3", K_LOAD0, 29'h0030006, 16'h1234};
        rows[2] = '{"loader_sound_ignored", K_LOAD1, 29'h0000100, 16'hbeef};
        rows[3] = '{"cpu_word0", K_CPU, 29'h0000100, 16'h0};
        rows[4] = '{"cpu_word3", K_CPU, 29'h0012347, 16'h0};
        rows[5] = '{"video_beat", K_VIDEO, 29'h00abcde, 16'h0};
        rows[6] = '{"audio_beat", K_AUDIO, 29'h1ff0001, 16'h0};
        rows[7] = '{"all_three_priority", K_ALL, 29'h0040000, 16'h0};
        rows[8] = '{"download_hold", K_HOLD, 29'h0050000, 16'h0};
        rows[9] = '{"random_stress", K_RANDOM, 29'h0, 16'h0};
        reset = 1;
        {cpu_req, video_req, audio_req} = '0;
        cpu_addr = '0;
        video_addr = '0;
        audio_addr = '0;
        {ioctl_download, ioctl_wr} = '0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_index = '0;
        repeat (2) @(posedge fixed_50m_clk);
        #1 reset = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cur_name = rows[i].name;
            case (rows[i].kind)
                K_LOAD0:  run_loader(rows[i], 8'd0);
                K_LOAD1:  run_loader(rows[i], 8'd1);
                K_CPU:    issue_cpu(rows[i].addr[22:0]);
                K_VIDEO:  issue_video(rows[i].addr);
                K_AUDIO:  issue_audio(rows[i].addr);
                K_ALL:    run_three(rows[i], 1'b0);
                K_HOLD:   run_three(rows[i], 1'b1);
                default:  run_random(rows[i], 20);
            endcase
            wait_acks();
            repeat (3) step_cycle();
        end
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/tb_ddram_model.sv
`timescale 1ns/1ps

module tb_ddram_model (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    input  logic                     ddram_rd,
    input  logic                     ddram_we,
    input  pgm_arb_pkg::ddram_addr_t ddram_addr,
    input  pgm_arb_pkg::ddram_data_t ddram_din,
    input  pgm_arb_pkg::ddram_be_t   ddram_be,
    output logic                     ddram_busy,
    output pgm_arb_pkg::ddram_data_t ddram_dout,
    output logic                     ddram_dout_ready,
    output int                       wr_count,
    output pgm_arb_pkg::ddram_addr_t wr_addr,
    output pgm_arb_pkg::ddram_data_t wr_data,
    output pgm_arb_pkg::ddram_be_t   wr_be,
    output int                       max_in_flight
);
    import pgm_arb_pkg::*;

    logic [31:0] lfsr = 32'hb46927e9;
    ddram_addr_t addr_q[$];
    longint      due_q[$];
    longint      cycle;
    longint      last_due;
    longint      due;
    int          in_flight;

    // One Galois step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Memory content is a fixed function of the beat address
    function automatic ddram_data_t beat_of(input ddram_addr_t a);
        return {a, 3'b101, ~a, 3'b010};
    endfunction

    always @(posedge fixed_50m_clk) begin
        if (reset) begin
            ddram_busy       <= 1'b0;
            ddram_dout_ready <= 1'b0;
            wr_count         <= 0;
            max_in_flight    <= 0;
            addr_q.delete();
            due_q.delete();
            cycle     = 0;
            last_due  = 0;
            in_flight = 0;
        end else begin
            if (ddram_rd && !ddram_busy) begin
                due = cycle + 1 + (rand_bits(3) % 6);  // 1 to 6 cycles
                if (due <= last_due) due = last_due + 1;  // Keep return order
                last_due = due;
                addr_q.push_back(ddram_addr);
                due_q.push_back(due);
                in_flight++;
                if (in_flight > max_in_flight) max_in_flight <= in_flight;
            end
            if (ddram_we && !ddram_busy) begin
                wr_count <= wr_count + 1;
                wr_addr  <= ddram_addr;
                wr_data  <= ddram_din;
                wr_be    <= ddram_be;
            end
            ddram_dout_ready <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                ddram_dout_ready <= 1'b1;
                ddram_dout       <= beat_of(addr_q.pop_front());
                void'(due_q.pop_front());
                in_flight--;
            end
            ddram_busy <= (rand_bits(2) == 8'd3);  // Busy about one cycle in four
            cycle++;
        end
    end

endmodule

//--- verilog/pgm_ddram_arbiter.sv
`timescale 1ns/1ps

module pgm_ddram_arbiter #(
    parameter int ISSUE_DEPTH     = 2,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,

    // Read clients
    input  logic                     cpu_req,
    input  pgm_arb_pkg::cpu_addr_t   cpu_addr,
    input  logic                     video_req,
    input  pgm_arb_pkg::ddram_addr_t video_addr,
    input  logic                     audio_req,
    input  pgm_arb_pkg::ddram_addr_t audio_addr,

    // ROM loader
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,
    input  logic [26:0]              ioctl_addr,
    input  logic [15:0]              ioctl_dout,
    input  logic [7:0]               ioctl_index,
    output logic                     ioctl_wait,

    // DDRAM port
    output logic                     ddram_rd,
    output logic                     ddram_we,
    output pgm_arb_pkg::ddram_addr_t ddram_addr,
    output pgm_arb_pkg::ddram_data_t ddram_din,
    output pgm_arb_pkg::ddram_be_t   ddram_be,
    input  pgm_arb_pkg::ddram_data_t ddram_dout,
    input  logic                     ddram_busy,
    input  logic                     ddram_dout_ready,

    // Responses
    output logic                     cpu_ack,
    output pgm_arb_pkg::cpu_word_t   cpu_data,
    output logic                     video_ack,
    output pgm_arb_pkg::ddram_data_t video_data,
    output logic                     audio_ack,
    output pgm_arb_pkg::ddram_data_t audio_data
);
    import pgm_arb_pkg::*;

    logic        load_pending;
    ddram_addr_t load_addr;
    ddram_data_t load_data;
    ddram_be_t   load_be;

    read_cmd_if cmd_bus ();
    read_tag_if tag_bus ();

    request_scheduler #(
        .ISSUE_DEPTH(ISSUE_DEPTH)
    ) request_scheduler_inst (
        .fixed_50m_clk(fixed_50m_clk), .reset(reset),
        .cpu_req(cpu_req),     .cpu_addr(cpu_addr),
        .video_req(video_req), .video_addr(video_addr),
        .audio_req(audio_req), .audio_addr(audio_addr),
        .download(ioctl_download),
        .cmd(cmd_bus.sched)
    );

    ddram_issue #(
        .ISSUE_DEPTH(ISSUE_DEPTH),
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) ddram_issue_inst (
        .fixed_50m_clk(fixed_50m_clk), .reset(reset),
        .cmd(cmd_bus.issue), .tag(tag_bus.issue),
        .load_pending(load_pending), .load_addr(load_addr),
        .load_data(load_data),       .load_be(load_be),
        .ddram_busy(ddram_busy), .ddram_rd(ddram_rd), .ddram_we(ddram_we),
        .ddram_addr(ddram_addr), .ddram_din(ddram_din), .ddram_be(ddram_be)
    );

    read_return_router #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) read_return_router_inst (
        .fixed_50m_clk(fixed_50m_clk), .reset(reset),
        .tag(tag_bus.router),
        .ddram_dout(ddram_dout), .ddram_dout_ready(ddram_dout_ready),
        .cpu_ack(cpu_ack),     .cpu_data(cpu_data),
        .video_ack(video_ack), .video_data(video_data),
        .audio_ack(audio_ack), .audio_data(audio_data)
    );

    loader_write_latch loader_write_latch_inst (
        .fixed_50m_clk(fixed_50m_clk), .reset(reset),
        .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
        .ddram_busy(ddram_busy),
        .load_pending(load_pending), .load_addr(load_addr),
        .load_data(load_data), .load_be(load_be),
        .ioctl_wait(ioctl_wait)
    );

endmodule

//--- verilog/loader_write_latch.sv
`timescale 1ns/1ps

module loader_write_latch (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,
    input  logic [26:0]              ioctl_addr,
    input  logic [15:0]              ioctl_dout,
    input  logic [7:0]               ioctl_index,
    input  logic                     ddram_busy,
    output logic                     load_pending,
    output pgm_arb_pkg::ddram_addr_t load_addr,
    output pgm_arb_pkg::ddram_data_t load_data,
    output pgm_arb_pkg::ddram_be_t   load_be,
    output logic                     ioctl_wait
);
    import pgm_arb_pkg::*;

    loader_state_e state;
    logic          rom_wr;

    // Sound RAM writes (index 1) are dropped here
    assign rom_wr = ioctl_wr && (ioctl_index == LOADER_ROM_INDEX);

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            state <= LOAD_IDLE;
        end else begin
            case (state)
                LOAD_IDLE:    if (rom_wr) state <= LOAD_PENDING;
                LOAD_PENDING: if (!ddram_busy) state <= LOAD_IDLE;  // DDRAM took it
                default:      state <= LOAD_IDLE;
            endcase
        end
    end

    // Address, data and lanes captured with the write
    always_ff @(posedge fixed_50m_clk) begin
        if (state == LOAD_IDLE && rom_wr) begin
            load_addr <= {5'd0, ioctl_addr[26:3]};
            load_data <= {4{ioctl_dout}};
            case (ioctl_addr[2:1])
                2'd0:    load_be <= 8'h03;
                2'd1:    load_be <= 8'h0C;
                2'd2:    load_be <= 8'h30;
                default: load_be <= 8'hC0;
            endcase
        end
    end

    assign load_pending = (state == LOAD_PENDING);
    assign ioctl_wait   = load_pending;  // Loader stalls until the write lands

endmodule

//--- verilog/read_return_router.sv
`timescale 1ns/1ps

module read_return_router #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    read_tag_if.router               tag,
    input  pgm_arb_pkg::ddram_data_t ddram_dout,
    input  logic                     ddram_dout_ready,
    output logic                     cpu_ack,
    output pgm_arb_pkg::cpu_word_t   cpu_data,
    output logic                     video_ack,
    output pgm_arb_pkg::ddram_data_t video_data,
    output logic                     audio_ack,
    output pgm_arb_pkg::ddram_data_t audio_data
);
    import pgm_arb_pkg::*;

    localparam int PW = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CW = $clog2(MAX_OUTSTANDING + 1);

    client_e       q_client [MAX_OUTSTANDING];
    word_sel_t     q_sel    [MAX_OUTSTANDING];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] q_count;
    logic          pop;
    client_e       head_client;
    cpu_word_t     sel_word;

    function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
        return (ptr == PW'(MAX_OUTSTANDING - 1)) ? '0 : ptr + PW'(1);
    endfunction

    assign pop         = ddram_dout_ready && (q_count != '0);
    assign head_client = q_client[rd_ptr];
    assign sel_word    = ddram_dout[{q_sel[rd_ptr], 4'b0000} +: 16];

    // Tags kept in issue order, DDRAM returns in order
    always_ff @(posedge fixed_50m_clk) begin
        if (tag.push) begin
            q_client[wr_ptr] <= tag.tag.client;
            q_sel[wr_ptr]    <= tag.tag.word_sel;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            cpu_ack    <= 1'b0;
            video_ack  <= 1'b0;
            audio_ack  <= 1'b0;
            tag.credit <= 1'b0;
        end else begin
            if (tag.push) wr_ptr <= bump(wr_ptr);
            if (pop)      rd_ptr <= bump(rd_ptr);
            case ({tag.push, pop})
                2'b10:   q_count <= q_count + CW'(1);
                2'b01:   q_count <= q_count - CW'(1);
                default: q_count <= q_count;
            endcase
            cpu_ack    <= pop && (head_client == CLIENT_CPU);
            video_ack  <= pop && (head_client == CLIENT_VIDEO);
            audio_ack  <= pop && (head_client == CLIENT_AUDIO);
            tag.credit <= pop;  // Credit goes back with the ack
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (pop && head_client == CLIENT_CPU) begin
            cpu_data <= {sel_word[7:0], sel_word[15:8]};  // Big-endian CPU
        end
        if (pop && head_client == CLIENT_VIDEO) video_data <= ddram_dout;
        if (pop && head_client == CLIENT_AUDIO) audio_data <= ddram_dout;
    end

    // Every beat from DDRAM belongs to a read issued earlier
    a_no_orphan_beat: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_dout_ready |-> q_count != '0);

endmodule

//--- verilog/ddram_issue.sv
`timescale 1ns/1ps

module ddram_issue #(
    parameter int ISSUE_DEPTH     = 2,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    read_cmd_if.issue                cmd,
    read_tag_if.issue                tag,
    input  logic                     load_pending,
    input  pgm_arb_pkg::ddram_addr_t load_addr,
    input  pgm_arb_pkg::ddram_data_t load_data,
    input  pgm_arb_pkg::ddram_be_t   load_be,
    input  logic                     ddram_busy,
    output logic                     ddram_rd,
    output logic                     ddram_we,
    output pgm_arb_pkg::ddram_addr_t ddram_addr,
    output pgm_arb_pkg::ddram_data_t ddram_din,
    output pgm_arb_pkg::ddram_be_t   ddram_be
);
    import pgm_arb_pkg::*;

    localparam int PW = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CW = $clog2(ISSUE_DEPTH + 1);
    localparam int OW = $clog2(MAX_OUTSTANDING + 1);

    read_cmd_t     cmd_mem [ISSUE_DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] buf_count;
    logic [OW-1:0] rd_credits;  // Reads still allowed in flight
    read_cmd_t     head;
    logic          rd_accept;

    function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
        return (ptr == PW'(ISSUE_DEPTH - 1)) ? '0 : ptr + PW'(1);
    endfunction

    assign head      = cmd_mem[rd_ptr];
    assign rd_accept = ddram_rd && !ddram_busy;

    // Loader write takes the port over buffered reads
    assign ddram_rd   = (buf_count != '0) && (rd_credits != '0) && !load_pending;
    assign ddram_we   = load_pending;
    assign ddram_addr = load_pending ? load_addr : head.addr;
    assign ddram_din  = load_data;
    assign ddram_be   = load_pending ? load_be : 8'hFF;

    assign tag.push         = rd_accept;
    assign tag.tag.client   = head.client;
    assign tag.tag.word_sel = head.word_sel;
    assign cmd.credit       = rd_accept;  // Slot freed as the head leaves

    always_ff @(posedge fixed_50m_clk) begin
        if (cmd.valid) begin
            cmd_mem[wr_ptr] <= cmd.cmd;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            buf_count  <= '0;
            rd_credits <= OW'(MAX_OUTSTANDING);
        end else begin
            if (cmd.valid) wr_ptr <= bump(wr_ptr);
            if (rd_accept) rd_ptr <= bump(rd_ptr);
            case ({cmd.valid, rd_accept})
                2'b10:   buf_count <= buf_count + CW'(1);
                2'b01:   buf_count <= buf_count - CW'(1);
                default: buf_count <= buf_count;
            endcase
            case ({rd_accept, tag.credit})
                2'b10:   rd_credits <= rd_credits - OW'(1);
                2'b01:   rd_credits <= rd_credits + OW'(1);
                default: rd_credits <= rd_credits;
            endcase
        end
    end

    // Scheduler credits keep it off a full buffer
    a_no_buffer_overflow: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        cmd.valid |-> buf_count < CW'(ISSUE_DEPTH));

    // In flight is MAX_OUTSTANDING minus credits, so a surplus router credit breaks it
    a_outstanding_limit: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        rd_credits <= OW'(MAX_OUTSTANDING));

endmodule

//--- verilog/request_scheduler.sv
`timescale 1ns/1ps

module request_scheduler #(
    parameter int ISSUE_DEPTH = 2
) (
    input  logic                   fixed_50m_clk,
    input  logic                   reset,
    input  logic                   cpu_req,
    input  pgm_arb_pkg::cpu_addr_t cpu_addr,
    input  logic                   video_req,
    input  pgm_arb_pkg::ddram_addr_t video_addr,
    input  logic                   audio_req,
    input  pgm_arb_pkg::ddram_addr_t audio_addr,
    input  logic                   download,
    read_cmd_if.sched              cmd
);
    import pgm_arb_pkg::*;

    localparam int CW = $clog2(ISSUE_DEPTH + 1);

    logic          cpu_pend, video_pend, audio_pend;
    cpu_addr_t     cpu_addr_q;
    ddram_addr_t   video_addr_q, audio_addr_q;
    logic [CW-1:0] credits;
    logic          can_offer;
    logic          grant_cpu, grant_video, grant_audio;
    read_cmd_t     next_cmd;

    // A credit arriving this cycle may be spent at once
    assign can_offer = !download && ((credits != '0) || cmd.credit) &&
                       (cpu_pend || video_pend || audio_pend);

    assign grant_cpu   = can_offer && cpu_pend;
    assign grant_video = can_offer && !cpu_pend && video_pend;
    assign grant_audio = can_offer && !cpu_pend && !video_pend && audio_pend;

    // Fixed priority pick
    always_comb begin
        next_cmd.client   = CLIENT_AUDIO;
        next_cmd.addr     = audio_addr_q;
        next_cmd.word_sel = '0;
        if (cpu_pend) begin
            next_cmd.client   = CLIENT_CPU;
            next_cmd.addr     = {8'd0, cpu_addr_q[22:2]};  // Beat holds four words
            next_cmd.word_sel = cpu_addr_q[1:0];
        end else if (video_pend) begin
            next_cmd.client = CLIENT_VIDEO;
            next_cmd.addr   = video_addr_q;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            cpu_pend   <= 1'b0;
            video_pend <= 1'b0;
            audio_pend <= 1'b0;
            cmd.valid  <= 1'b0;
            credits    <= CW'(ISSUE_DEPTH);
        end else begin
            cpu_pend   <= cpu_req || (cpu_pend && !grant_cpu);
            video_pend <= video_req || (video_pend && !grant_video);
            audio_pend <= audio_req || (audio_pend && !grant_audio);
            cmd.valid  <= can_offer;
            if (can_offer && !cmd.credit) begin
                credits <= credits - CW'(1);
            end else if (!can_offer && cmd.credit) begin
                credits <= credits + CW'(1);
            end
        end
    end

    // Captured addresses and the offered command
    always_ff @(posedge fixed_50m_clk) begin
        if (cpu_req)   cpu_addr_q   <= cpu_addr;
        if (video_req) video_addr_q <= video_addr;
        if (audio_req) audio_addr_q <= audio_addr;
        if (can_offer) cmd.cmd      <= next_cmd;
    end

    // A client waits for its ack before asking again
    a_no_req_while_pending: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        !(cpu_req && cpu_pend) && !(video_req && video_pend) && !(audio_req && audio_pend));

endmodule

//--- verilog/read_tag_if.sv
`timescale 1ns/1ps

// Issue stage to return router, one tag per read accepted by DDRAM
interface read_tag_if;
    import pgm_arb_pkg::*;

    typedef struct packed {
        client_e   client;
        word_sel_t word_sel;
    } read_tag_t;

    logic      push;
    read_tag_t tag;
    logic      credit;  // Beat returned to its client

    modport issue (
        output push,
        output tag,
        input  credit
    );

    modport router (
        input  push,
        input  tag,
        output credit
    );

endinterface

//--- verilog/read_cmd_if.sv
`timescale 1ns/1ps

// Scheduler to issue stage, credit based
interface read_cmd_if;
    import pgm_arb_pkg::*;

    logic      valid;   // One cycle per command
    read_cmd_t cmd;
    logic      credit;  // Buffer slot freed

    modport sched (
        output valid,
        output cmd,
        input  credit
    );

    modport issue (
        input  valid,
        input  cmd,
        output credit
    );

endinterface

//--- verilog/pgm_arb_pkg.sv
package pgm_arb_pkg;

    // Read clients of the DDRAM port, listed in priority order
    typedef enum logic [1:0] {
        CLIENT_CPU   = 2'd0,
        CLIENT_VIDEO = 2'd1,
        CLIENT_AUDIO = 2'd2
    } client_e;

    // ROM loader write latch
    typedef enum logic {
        LOAD_IDLE    = 1'b0,
        LOAD_PENDING = 1'b1
    } loader_state_e;

    typedef logic [28:0] ddram_addr_t;  // 64-bit beat address
    typedef logic [63:0] ddram_data_t;
    typedef logic [7:0]  ddram_be_t;

    typedef logic [22:0] cpu_addr_t;    // CPU address bits 23:1
    typedef logic [15:0] cpu_word_t;
    typedef logic [1:0]  word_sel_t;    // 16-bit word inside a beat

    // One scheduled read
    typedef struct packed {
        client_e     client;
        ddram_addr_t addr;
        word_sel_t   word_sel;
    } read_cmd_t;

    // ioctl_index value of a ROM download
    localparam logic [7:0] LOADER_ROM_INDEX = 8'd0;

endpackage
